//--- hw/usb_host_pkg.sv
/* Shared types and helpers for the full-speed USB host link.
   Imported by the line interface, the packet transmitter and the packet receiver. */
package usb_host_pkg;

  // Clock cycles per bit at 12 Mbit/s from a 48 MHz clock
  parameter int BitClksDefault = 4;

  // Low nibble of the PID byte; the high nibble on the wire is its complement
  typedef enum logic [3:0] {
    OUT   = 4'h1,
    IN    = 4'h9,
    SETUP = 4'hD,
    SOF   = 4'h5,
    ACK   = 4'h2,
    NAK   = 4'hA,
    STALL = 4'hE,
    DATA0 = 4'h3
  } usb_pid_e;

  // Bus state after orientation correction
  typedef enum logic [1:0] {
    LINE_SE0 = 2'b00,
    LINE_J   = 2'b01,
    LINE_K   = 2'b10,
    LINE_SE1 = 2'b11
  } usb_line_e;

  // One packet for the transmitter, 16 bits
  typedef struct packed {
    usb_pid_e   pid;
    logic       has_token;
    logic [6:0] addr;
    logic [3:0] endp;
  } usb_tx_req_t;

  // One packet seen by the receiver, 9 bits
  typedef struct packed {
    usb_pid_e   pid;
    logic       pid_err;
    // Unstuffed bits after the PID, saturating at 15
    logic [3:0] bits;
  } usb_rx_pkt_t;

  // Token PIDs are the only ones that carry address and endpoint
  function automatic logic usb_pid_is_token(input usb_pid_e pid);
    return (pid == OUT) || (pid == IN) || (pid == SETUP) || (pid == SOF);
  endfunction

  // CRC5 over the 11 token bits, data[0] first on the wire.
  // The result is ordered so that bit 0 is the first CRC bit sent.
  function automatic logic [4:0] usb_crc5(input logic [10:0] data);
    logic [4:0] crc;
    logic       fb;
    logic [4:0] field;
    crc = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb  = crc[4] ^ data[i];
      crc = {crc[3:0], 1'b0};
      if (fb) begin
        crc = crc ^ 5'h05;
      end
    end
    // Remainder is inverted and goes out high bit first
    for (int i = 0; i < 5; i++) begin
      field[i] = ~crc[4 - i];
    end
    return field;
  endfunction

endpackage

//--- hw/usb_line_if.sv
/* Pin-level line interface between the host link and the device pins.
   Merges host and device drive, handles pull-up detection and pin flip. */
`timescale 1ns/1ns

module usb_line_if (
  input  logic                    clk_48MHz_i,
  input  logic                    rst_ni,
  input  logic                    dp_d2p,
  input  logic                    dp_en_d2p,
  input  logic                    dn_d2p,
  input  logic                    dn_en_d2p,
  input  logic                    pullupdp_d2p,
  input  logic                    pullupdn_d2p,
  input  usb_host_pkg::usb_line_e tx_line,
  input  logic                    tx_oe,
  output logic                    dp_p2d,
  output logic                    dn_p2d,
  output logic                    dp_en_p2d,
  output logic                    dn_en_p2d,
  output logic                    sense_p2d,
  output logic                    connected,
  output usb_host_pkg::usb_line_e rx_line
);
  import usb_host_pkg::*;

  logic flip;
  logic host_dp;
  logic host_dn;
  logic drive_dp;
  logic drive_dn;
  logic bus_dp;
  logic bus_dn;
  logic norm_dp;
  logic norm_dn;

  // Pull-up on D- means the device has its pins swapped
  assign flip      = pullupdn_d2p;
  assign connected = pullupdp_d2p | pullupdn_d2p;

  assign dp_en_p2d = tx_oe;
  assign dn_en_p2d = tx_oe;

  // Host line state as D+/D- levels before the flip
  always_comb begin
    case (tx_line)
      LINE_J:   {host_dp, host_dn} = 2'b10;
      LINE_K:   {host_dp, host_dn} = 2'b01;
      LINE_SE1: {host_dp, host_dn} = 2'b11;
      default:  {host_dp, host_dn} = 2'b00;
    endcase
  end

  assign drive_dp = flip ? host_dn : host_dp;
  assign drive_dn = flip ? host_dp : host_dn;

  // Device drive wins, then host drive, then the pull-up idle level
  always_comb begin
    if (dp_en_d2p) begin
      dp_p2d = dp_d2p;
    end else if (tx_oe) begin
      dp_p2d = drive_dp;
    end else begin
      dp_p2d = pullupdp_d2p;
    end
    if (dn_en_d2p) begin
      dn_p2d = dn_d2p;
    end else if (tx_oe) begin
      dn_p2d = drive_dn;
    end else begin
      dn_p2d = pullupdn_d2p;
    end
  end

  // Device side of the bus only, undone for flip
  assign bus_dp  = dp_en_d2p ? dp_d2p : pullupdp_d2p;
  assign bus_dn  = dn_en_d2p ? dn_d2p : pullupdn_d2p;
  assign norm_dp = flip ? bus_dn : bus_dp;
  assign norm_dn = flip ? bus_dp : bus_dn;

  always_ff @(posedge clk_48MHz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sense_p2d <= 1'b0;
      rx_line   <= LINE_J;
    end else begin
      sense_p2d <= 1'b1;
      case ({norm_dp, norm_dn})
        2'b10:   rx_line <= LINE_J;
        2'b01:   rx_line <= LINE_K;
        2'b11:   rx_line <= LINE_SE1;
        default: rx_line <= LINE_SE0;
      endcase
    end
  end

  // Transmitter must never drive a bus with no device attached
  a_oe_needs_device: assert property (
    @(posedge clk_48MHz_i) disable iff (!rst_ni) tx_oe |-> connected
  );

endmodule

//--- hw/usb_packet_tx.sv
/* Packet transmitter for the host link.
   Sends SYNC, PID and optional token fields with CRC5, stuffing, NRZI and EOP. */
`timescale 1ns/1ns

module usb_packet_tx #(
  parameter int BitClks = 4
) (
  input  logic                      clk_48MHz_i,
  input  logic                      rst_ni,
  input  logic                      tx_start,
  input  usb_host_pkg::usb_tx_req_t tx_req,
  input  logic                      connected,
  output logic                      tx_busy,
  output logic                      tx_done,
  output logic                      tx_oe,
  output usb_host_pkg::usb_line_e   tx_line
);
  import usb_host_pkg::*;

  localparam int CntW = $clog2(BitClks + 1);

  typedef enum logic [2:0] {IDLE, SYNC, PID, TOKEN, CRC, EOP, IDLE_J} tx_state_e;

  tx_state_e       state;
  logic [CntW-1:0] bit_cnt;
  logic [31:0]     pkt_q;
  logic [31:0]     packet;
  logic [5:0]      data_cnt;
  logic [5:0]      data_len;
  logic [2:0]      ones_cnt;
  logic            eop_second;
  logic            accept;
  logic            bit_end;

  // Which field a given bit index of the packet image belongs to
  function automatic tx_state_e field_state(input logic [5:0] idx);
    if (idx < 6'd8) begin
      return SYNC;
    end else if (idx < 6'd16) begin
      return PID;
    end else if (idx < 6'd27) begin
      return TOKEN;
    end
    return CRC;
  endfunction

  function automatic usb_line_e nrzi_toggle(input usb_line_e level);
    return (level == LINE_J) ? LINE_K : LINE_J;
  endfunction

  assign accept  = tx_start && !tx_busy && connected;
  assign bit_end = bit_cnt == CntW'(BitClks - 1);

  // Packet image sent LSB first; SYNC is seven zeros and a one
  assign packet = {usb_crc5({tx_req.endp, tx_req.addr}), tx_req.endp, tx_req.addr,
                   ~tx_req.pid, tx_req.pid, 8'b1000_0000};

  always_ff @(posedge clk_48MHz_i) begin
    if (accept) begin
      pkt_q <= packet;
    end
  end

  always_ff @(posedge clk_48MHz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= IDLE;
      bit_cnt    <= '0;
      data_cnt   <= '0;
      data_len   <= '0;
      ones_cnt   <= '0;
      eop_second <= 1'b0;
      tx_busy    <= 1'b0;
      tx_done    <= 1'b0;
      tx_oe      <= 1'b0;
      tx_line    <= LINE_J;
    end else begin
      tx_done <= 1'b0;
      bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
      if (accept) begin
        // First SYNC bit is a zero, so the line goes from idle J to K
        state      <= SYNC;
        bit_cnt    <= '0;
        data_cnt   <= 6'd1;
        data_len   <= tx_req.has_token ? 6'd32 : 6'd16;
        ones_cnt   <= '0;
        eop_second <= 1'b0;
        tx_busy    <= 1'b1;
        tx_oe      <= 1'b1;
        tx_line    <= LINE_K;
      end else if (bit_end) begin
        case (state)
          SYNC, PID, TOKEN, CRC: begin
            if (ones_cnt == 3'd6) begin
              // Stuffed zero, counted from SYNC onwards and also before EOP
              tx_line  <= nrzi_toggle(tx_line);
              ones_cnt <= '0;
            end else if (data_cnt == data_len) begin
              state   <= EOP;
              tx_line <= LINE_SE0;
            end else begin
              state    <= field_state(data_cnt);
              data_cnt <= data_cnt + 6'd1;
              if (pkt_q[data_cnt[4:0]]) begin
                ones_cnt <= ones_cnt + 3'd1;
              end else begin
                tx_line  <= nrzi_toggle(tx_line);
                ones_cnt <= '0;
              end
            end
          end
          EOP: begin
            eop_second <= 1'b1;
            if (eop_second) begin
              state   <= IDLE_J;
              tx_line <= LINE_J;
            end
          end
          IDLE_J: begin
            state <= IDLE;
            tx_oe <= 1'b0;
          end
          default: ;
        endcase
      end
      // Done and not busy in the last cycle of the J bit
      if (state == IDLE_J && bit_cnt == CntW'(BitClks - 2)) begin
        tx_done <= 1'b1;
        tx_busy <= 1'b0;
      end
    end
  end

  a_no_start_when_busy: assert property (
    @(posedge clk_48MHz_i) disable iff (!rst_ni) tx_start |-> !tx_busy
  );

  a_token_pid: assert property (
    @(posedge clk_48MHz_i) disable iff (!rst_ni)
      tx_start && tx_req.has_token |-> usb_pid_is_token(tx_req.pid)
  );

endmodule

//--- hw/usb_packet_rx.sv
/* Packet receiver for the host link.
   Finds SYNC, undoes NRZI and stuffing, and reports the PID at EOP. */
`timescale 1ns/1ns

module usb_packet_rx #(
  parameter int BitClks = 4
) (
  input  logic                        clk_48MHz_i,
  input  logic                        rst_ni,
  input  usb_host_pkg::usb_line_e     rx_line,
  input  logic                        tx_oe,
  output logic                        rx_valid,
  output usb_host_pkg::usb_rx_pkt_t   rx_pkt
);
  import usb_host_pkg::*;

  localparam int CntW        = $clog2(BitClks + 1);
  localparam int SamplePhase = BitClks / 2;

  typedef enum logic [2:0] {HUNT, SYNC, PID, BODY, EOP} rx_state_e;

  usb_line_e       line_q;
  usb_line_e       last_level;
  usb_line_e       s_line;
  logic [CntW-1:0] phase_q;
  logic [CntW-1:0] phase;
  logic            sample;
  logic            s_valid;
  logic            s_bit;
  logic            s_jk;
  logic            data_bit;
  rx_state_e       state;
  logic [2:0]      fld_cnt;
  logic [2:0]      ones_cnt;
  logic [7:0]      pid_sr;
  logic [3:0]      body_cnt;

  // Every transition restarts the bit phase
  assign phase  = (rx_line != line_q) ? '0 : phase_q;
  assign sample = (phase == CntW'(SamplePhase)) && !tx_oe;

  always_ff @(posedge clk_48MHz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q     <= LINE_J;
      phase_q    <= '0;
      last_level <= LINE_J;
      s_valid    <= 1'b0;
    end else begin
      line_q  <= rx_line;
      phase_q <= (phase == CntW'(BitClks - 1)) ? '0 : phase + 1'b1;
      s_valid <= sample;
      if (tx_oe) begin
        last_level <= LINE_J;
      end else if (sample && (rx_line == LINE_J || rx_line == LINE_K)) begin
        last_level <= rx_line;
      end
    end
  end

  // NRZI decode, a one is no change of level
  always_ff @(posedge clk_48MHz_i) begin
    if (sample) begin
      s_line <= rx_line;
      s_bit  <= rx_line == last_level;
    end
  end

  assign s_jk     = (s_line == LINE_J) || (s_line == LINE_K);
  // A J/K bit that is not a stuffed zero
  assign data_bit = s_valid && !tx_oe && s_jk && (ones_cnt != 3'd6);

  always_ff @(posedge clk_48MHz_i) begin
    if (data_bit && state == PID) begin
      pid_sr <= {s_bit, pid_sr[7:1]};
    end
  end

  always_ff @(posedge clk_48MHz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state    <= HUNT;
      fld_cnt  <= '0;
      ones_cnt <= '0;
      body_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (tx_oe) begin
        state <= HUNT;
      end else if (s_valid) begin
        case (state)
          HUNT: begin
            if (s_line == LINE_K && !s_bit) begin
              state   <= SYNC;
              fld_cnt <= 3'd1;
            end
          end
          SYNC: begin
            // Seven zeros then a one; anything else restarts the hunt
            if (!s_jk) begin
              state <= HUNT;
            end else if (!s_bit) begin
              if (fld_cnt == 3'd7) begin
                state <= HUNT;
              end else begin
                fld_cnt <= fld_cnt + 3'd1;
              end
            end else if (fld_cnt == 3'd7) begin
              state    <= PID;
              fld_cnt  <= '0;
              ones_cnt <= 3'd1;
            end else begin
              state <= HUNT;
            end
          end
          PID, BODY: begin
            if (s_line == LINE_SE0) begin
              state <= (state == BODY) ? EOP : HUNT;
            end else if (s_line == LINE_SE1) begin
              state <= HUNT;
            end else if (ones_cnt == 3'd6) begin
              // Stuffed bit must be a zero
              if (s_bit) begin
                state <= HUNT;
              end
              ones_cnt <= '0;
            end else begin
              ones_cnt <= s_bit ? ones_cnt + 3'd1 : 3'd0;
              if (state == PID) begin
                fld_cnt <= fld_cnt + 3'd1;
                if (fld_cnt == 3'd7) begin
                  state    <= BODY;
                  body_cnt <= '0;
                end
              end else if (body_cnt != 4'd15) begin
                body_cnt <= body_cnt + 4'd1;
              end
            end
          end
          EOP: begin
            if (s_line == LINE_J) begin
              rx_valid <= 1'b1;
              state    <= HUNT;
            end else if (s_line != LINE_SE0) begin
              state <= HUNT;
            end
          end
          default: state <= HUNT;
        endcase
      end
    end
  end

  assign rx_pkt.pid     = usb_pid_e'(pid_sr[3:0]);
  assign rx_pkt.pid_err = pid_sr[7:4] != ~pid_sr[3:0];
  assign rx_pkt.bits    = body_cnt;

  // Host drive and device reports must not overlap
  a_no_rx_during_tx: assert property (
    @(posedge clk_48MHz_i) disable iff (!rst_ni) rx_valid |-> !tx_oe
  );

endmodule

//--- hw/usb_host_link.sv
/* Top level of the full-speed USB host link.
   Connects the line interface, the packet transmitter and the packet receiver. */
`timescale 1ns/1ns

module usb_host_link #(
  parameter int BitClks = usb_host_pkg::BitClksDefault
) (
  input  logic                      clk_48MHz_i,
  input  logic                      rst_ni,
  // Controller side
  input  logic                      tx_start,
  input  usb_host_pkg::usb_tx_req_t tx_req,
  output logic                      tx_busy,
  output logic                      tx_done,
  output logic                      rx_valid,
  output usb_host_pkg::usb_rx_pkt_t rx_pkt,
  output logic                      connected,
  // Device side
  input  logic                      dp_d2p,
  input  logic                      dp_en_d2p,
  input  logic                      dn_d2p,
  input  logic                      dn_en_d2p,
  input  logic                      pullupdp_d2p,
  input  logic                      pullupdn_d2p,
  output logic                      dp_p2d,
  output logic                      dn_p2d,
  output logic                      dp_en_p2d,
  output logic                      dn_en_p2d,
  output logic                      sense_p2d
);
  import usb_host_pkg::*;

  usb_line_e tx_line;
  usb_line_e rx_line;
  logic      tx_oe;

  usb_line_if u_line_if (
    .clk_48MHz_i,
    .rst_ni,
    .dp_d2p,
    .dp_en_d2p,
    .dn_d2p,
    .dn_en_d2p,
    .pullupdp_d2p,
    .pullupdn_d2p,
    .tx_line,
    .tx_oe,
    .dp_p2d,
    .dn_p2d,
    .dp_en_p2d,
    .dn_en_p2d,
    .sense_p2d,
    .connected,
    .rx_line
  );

  usb_packet_tx #(.BitClks(BitClks)) u_packet_tx (
    .clk_48MHz_i,
    .rst_ni,
    .tx_start,
    .tx_req,
    .connected,
    .tx_busy,
    .tx_done,
    .tx_oe,
    .tx_line
  );

  usb_packet_rx #(.BitClks(BitClks)) u_packet_rx (
    .clk_48MHz_i,
    .rst_ni,
    .rx_line,
    .tx_oe,
    .rx_valid,
    .rx_pkt
  );

endmodule

//--- test/usb_host_tb_util.svh
/* Reference models for the host link testbench: LCG, CRC5 and packet bit sequences.
   Included inside the testbench module body. */
`ifndef USB_HOST_TB_UTIL_SVH
`define USB_HOST_TB_UTIL_SVH

// Wire bits in send order, index 0 goes out first
typedef bit bit_q_t[$];

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Reflected CRC5 form, result bit 0 is sent first
function automatic logic [4:0] ref_crc5(input logic [6:0] addr, input logic [3:0] endp);
  logic [10:0] data;
  logic [4:0]  r;
  data = {endp, addr};
  r = 5'h1f;
  for (int i = 0; i < 11; i++) begin
    if (r[0] ^ data[i]) begin
      r = (r >> 1) ^ 5'h14;
    end else begin
      r = r >> 1;
    end
  end
  return ~r;
endfunction

// Address, endpoint and CRC5, all LSB first
function automatic bit_q_t ref_token_body(input logic [6:0] addr, input logic [3:0] endp);
  bit_q_t     q;
  logic [4:0] crc;
  crc = ref_crc5(addr, endp);
  for (int i = 0; i < 7; i++) q.push_back(addr[i]);
  for (int i = 0; i < 4; i++) q.push_back(endp[i]);
  for (int i = 0; i < 5; i++) q.push_back(crc[i]);
  return q;
endfunction

// SYNC, PID nibble, upper PID nibble and body before stuffing
function automatic bit_q_t ref_raw_bits(input logic [3:0] pid_code, input logic [3:0] pid_hi,
                                        input bit_q_t body);
  bit_q_t q;
  for (int i = 0; i < 7; i++) q.push_back(1'b0);
  q.push_back(1'b1);
  for (int i = 0; i < 4; i++) q.push_back(pid_code[i]);
  for (int i = 0; i < 4; i++) q.push_back(pid_hi[i]);
  foreach (body[i]) q.push_back(body[i]);
  return q;
endfunction

// A zero follows every run of six ones, even at the end
function automatic bit_q_t ref_stuff(input bit_q_t raw);
  bit_q_t q;
  int     ones;
  ones = 0;
  foreach (raw[i]) begin
    q.push_back(raw[i]);
    ones = raw[i] ? ones + 1 : 0;
    if (ones == 6) begin
      q.push_back(1'b0);
      ones = 0;
    end
  end
  return q;
endfunction

function automatic bit_q_t ref_unstuff(input bit_q_t stuffed);
  bit_q_t q;
  int     ones;
  bit     skip;
  ones = 0;
  skip = 1'b0;
  foreach (stuffed[i]) begin
    if (skip) begin
      skip = 1'b0;
      ones = 0;
    end else begin
      q.push_back(stuffed[i]);
      ones = stuffed[i] ? ones + 1 : 0;
      skip = (ones == 6);
    end
  end
  return q;
endfunction

`endif

//--- test/tb_usb_host_link.sv
/* Testbench for the USB host link with a device-side bus model.
   Checks token and handshake transmit, device packet receive and pin flip. */
`timescale 1ns/1ns

module tb_usb_host_link;
  import usb_host_pkg::*;

  `include "usb_host_tb_util.svh"

  localparam int BitClks = 4;
  localparam int Timeout = 500;

  logic        clk_48MHz_i;
  logic        rst_ni;
  logic        tx_start;
  usb_tx_req_t tx_req;
  logic        tx_busy;
  logic        tx_done;
  logic        rx_valid;
  usb_rx_pkt_t rx_pkt;
  logic        connected;
  logic        dp_d2p;
  logic        dp_en_d2p;
  logic        dn_d2p;
  logic        dn_en_d2p;
  logic        pullupdp_d2p;
  logic        pullupdn_d2p;
  logic        dp_p2d;
  logic        dn_p2d;
  logic        dp_en_p2d;
  logic        dn_en_p2d;
  logic        sense_p2d;

  logic [31:0] rng_state;
  logic        flip_tb;
  logic [1:0]  pins_q[$];
  usb_rx_pkt_t rx_last;
  bit_q_t      empty_q;
  int          busy_cyc   = 0;
  int          en_low_cyc = 0;
  int          done_count = 0;
  int          rx_count   = 0;
  int          errors     = 0;
  int          checks     = 0;

  usb_host_link #(.BitClks(BitClks)) DUT (.*);

  initial begin
    clk_48MHz_i = 1'b0;
    forever #2 clk_48MHz_i = ~clk_48MHz_i;
  end

  // Bus monitor, pins sampled mid-bit while the host transmits
  always @(negedge clk_48MHz_i) begin
    if (tx_busy) begin
      if (busy_cyc % BitClks == BitClks / 2) begin
        pins_q.push_back({dp_p2d, dn_p2d});
      end
      if (!dp_en_p2d || !dn_en_p2d) begin
        en_low_cyc = en_low_cyc + 1;
      end
      busy_cyc = busy_cyc + 1;
    end else begin
      busy_cyc = 0;
    end
    if (tx_done) done_count = done_count + 1;
    if (rx_valid) begin
      rx_count = rx_count + 1;
      rx_last  = rx_pkt;
    end
  end

  function automatic logic [15:0] rand16();
    rng_state = lcg_next(rng_state);
    return rng_state[31:16];
  endfunction

  function automatic usb_tx_req_t random_token();
    logic [15:0] r;
    usb_tx_req_t req;
    r = rand16();
    case (r[1:0])
      2'd0:    req.pid = OUT;
      2'd1:    req.pid = IN;
      2'd2:    req.pid = SETUP;
      default: req.pid = SOF;
    endcase
    req.has_token = 1'b1;
    req.addr      = r[8:2];
    req.endp      = r[12:9];
    return req;
  endfunction

  function automatic usb_pid_e random_handshake();
    int sel;
    sel = int'(rand16() % 16'd3);
    case (sel)
      0:       return ACK;
      1:       return NAK;
      default: return STALL;
    endcase
  endfunction

  // J is D+ high on a normal device, D- high on a flipped one
  function automatic logic [1:0] line_pins(input usb_line_e s);
    logic [1:0] p;
    case (s)
      LINE_J:   p = 2'b10;
      LINE_K:   p = 2'b01;
      LINE_SE0: p = 2'b00;
      default:  p = 2'b11;
    endcase
    return flip_tb ? {p[0], p[1]} : p;
  endfunction

  function automatic usb_line_e pin_level(input logic [1:0] pins);
    logic [1:0] p;
    p = flip_tb ? {pins[0], pins[1]} : pins;
    case (p)
      2'b10:   return LINE_J;
      2'b01:   return LINE_K;
      2'b11:   return LINE_SE1;
      default: return LINE_SE0;
    endcase
  endfunction

  task automatic check_bit(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_pid(input string name, input usb_pid_e got, input usb_pid_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rx_pkt(input string name, input usb_rx_pkt_t got,
                              input usb_rx_pkt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got pid=%h err=%b bits=%0d expected pid=%h err=%b bits=%0d",
               $time, name, got.pid, got.pid_err, got.bits, exp.pid, exp.pid_err, exp.bits);
    end
  endtask

  task automatic send_request(input usb_tx_req_t req);
    @(posedge clk_48MHz_i);
    tx_start <= 1'b1;
    tx_req   <= req;
    @(posedge clk_48MHz_i);
    tx_start <= 1'b0;
  endtask

  task automatic wait_tx_done(input int start, output bit seen);
    seen = 1'b0;
    for (int n = 0; n < Timeout && !seen; n++) begin
      @(posedge clk_48MHz_i);
      seen = (done_count != start);
    end
  endtask

  task automatic wait_rx_valid(input int start, output bit seen);
    seen = 1'b0;
    for (int n = 0; n < Timeout && !seen; n++) begin
      @(posedge clk_48MHz_i);
      seen = (rx_count != start);
    end
  endtask

  // Host transmit, decoded from the pins and compared with the reference bits
  task automatic run_tx(input usb_tx_req_t req);
    bit_q_t    body;
    bit_q_t    exp_bits;
    bit_q_t    got_bits;
    bit_q_t    plain;
    usb_line_e lvl;
    usb_line_e prev;
    bit        seen;
    int        start;
    int        n;
    if (req.has_token) body = ref_token_body(req.addr, req.endp);
    exp_bits = ref_stuff(ref_raw_bits(req.pid, ~req.pid, body));
    pins_q.delete();
    en_low_cyc = 0;
    start = done_count;
    send_request(req);
    wait_tx_done(start, seen);
    if (!seen) begin
      errors++;
      $display("Timed out waiting for tx_done after a packet request");
      return;
    end
    n = pins_q.size();
    prev = LINE_J;
    for (int i = 0; i < n - 3; i++) begin
      lvl = pin_level(pins_q[i]);
      got_bits.push_back(lvl == prev);
      prev = lvl;
    end
    check_bit("tx bit count", 32'(got_bits.size()), 32'(exp_bits.size()));
    for (int i = 0; i < got_bits.size() && i < exp_bits.size(); i++) begin
      check_bit($sformatf("tx bit %0d", i), 32'(got_bits[i]), 32'(exp_bits[i]));
    end
    if (n >= 3) begin
      check_bit("tx eop se0 1", 32'(pin_level(pins_q[n-3])), 32'(LINE_SE0));
      check_bit("tx eop se0 2", 32'(pin_level(pins_q[n-2])), 32'(LINE_SE0));
      check_bit("tx eop j", 32'(pin_level(pins_q[n-1])), 32'(LINE_J));
    end
    plain = ref_unstuff(got_bits);
    if (plain.size() >= 16) begin
      check_pid("tx pid", usb_pid_e'({plain[11], plain[10], plain[9], plain[8]}), req.pid);
    end
    // Both enables stay high for the whole packet
    check_bit("tx enable low cycles", 32'(en_low_cyc), 32'd0);
    repeat (2 * BitClks) @(negedge clk_48MHz_i);
    check_bit("tx_done count", 32'(done_count - start), 32'd1);
    check_bit("tx_busy", 32'(tx_busy), 32'd0);
    check_bit("dp_en_p2d", 32'(dp_en_p2d), 32'd0);
    check_bit("dn_en_p2d", 32'(dn_en_p2d), 32'd0);
  endtask

  task automatic drive_symbol(input usb_line_e s);
    logic [1:0] p;
    p = line_pins(s);
    @(posedge clk_48MHz_i);
    dp_d2p    <= p[1];
    dn_d2p    <= p[0];
    dp_en_d2p <= 1'b1;
    dn_en_d2p <= 1'b1;
    repeat (BitClks - 1) @(posedge clk_48MHz_i);
  endtask

  // Device packet, NRZI from idle J, then EOP and release
  task automatic run_rx(input logic [3:0] pid_code, input logic [3:0] pid_hi,
                        input bit_q_t body);
    bit_q_t      bits;
    usb_rx_pkt_t exp;
    usb_line_e   lvl;
    bit          seen;
    int          start;
    bits = ref_stuff(ref_raw_bits(pid_code, pid_hi, body));
    exp.pid     = usb_pid_e'(pid_code);
    exp.pid_err = (pid_hi != ~pid_code);
    exp.bits    = (body.size() > 15) ? 4'd15 : 4'(body.size());
    start = rx_count;
    lvl = LINE_J;
    foreach (bits[i]) begin
      if (!bits[i]) lvl = (lvl == LINE_J) ? LINE_K : LINE_J;
      drive_symbol(lvl);
    end
    drive_symbol(LINE_SE0);
    drive_symbol(LINE_SE0);
    drive_symbol(LINE_J);
    @(posedge clk_48MHz_i);
    dp_en_d2p <= 1'b0;
    dn_en_d2p <= 1'b0;
    wait_rx_valid(start, seen);
    if (!seen) begin
      errors++;
      $display("Timed out waiting for rx_valid after a device packet");
      return;
    end
    check_rx_pkt("rx_pkt", rx_last, exp);
    repeat (4 * BitClks) @(posedge clk_48MHz_i);
    check_bit("rx_valid count", 32'(rx_count - start), 32'd1);
  endtask

  initial begin
    usb_tx_req_t req;
    usb_tx_req_t tok;
    usb_pid_e    hs;
    bit_q_t      body;
    bit          seen;
    logic [15:0] r;
    rst_ni       = 1'b0;
    tx_start     = 1'b0;
    tx_req       = '0;
    dp_d2p       = 1'b0;
    dp_en_d2p    = 1'b0;
    dn_d2p       = 1'b0;
    dn_en_d2p    = 1'b0;
    pullupdp_d2p = 1'b0;
    pullupdn_d2p = 1'b0;
    flip_tb      = 1'b0;
    rng_state    = 32'h7a1dddd5;
    repeat (3) @(posedge clk_48MHz_i);
    rst_ni <= 1'b1;
    repeat (2) @(negedge clk_48MHz_i);

    // No device attached
    check_bit("tx_busy", 32'(tx_busy), 32'd0);
    check_bit("tx_done", 32'(tx_done), 32'd0);
    check_bit("rx_valid", 32'(rx_valid), 32'd0);
    check_bit("connected", 32'(connected), 32'd0);
    check_bit("sense_p2d", 32'(sense_p2d), 32'd1);
    send_request(random_token());
    wait_tx_done(done_count, seen);
    if (seen) begin
      errors++;
      $display("A request without a device produced tx_done");
    end
    check_bit("dp_en_p2d", 32'(dp_en_p2d), 32'd0);
    check_bit("dn_en_p2d", 32'(dn_en_p2d), 32'd0);

    @(posedge clk_48MHz_i);
    pullupdp_d2p <= 1'b1;
    repeat (2) @(negedge clk_48MHz_i);
    check_bit("connected", 32'(connected), 32'd1);

    // Long runs of ones force stuffing
    req = '{pid: OUT, has_token: 1'b1, addr: 7'h7f, endp: 4'hf};
    run_tx(req);
    req = '{pid: IN, has_token: 1'b1, addr: 7'h3f, endp: 4'h1};
    run_tx(req);
    repeat (18) run_tx(random_token());

    // Handshakes carry no token fields
    req = '{pid: ACK, has_token: 1'b0, addr: 7'h55, endp: 4'h3};
    run_tx(req);
    req.pid = NAK;
    run_tx(req);
    req.pid = STALL;
    run_tx(req);

    repeat (6) begin
      hs = random_handshake();
      run_rx(hs, ~hs, empty_q);
    end
    repeat (4) begin
      tok = random_token();
      run_rx(tok.pid, ~tok.pid, ref_token_body(tok.addr, tok.endp));
    end
    body.delete();
    body.push_back(1'b1);
    run_rx(DATA0, ~DATA0, body);
    body.delete();
    for (int i = 0; i < 7; i++) begin
      body.push_back(1'b1);
    end
    run_rx(DATA0, ~DATA0, body);
    body.delete();
    r = rand16();
    for (int i = 0; i < 14; i++) body.push_back(r[i]);
    run_rx(DATA0, ~DATA0, body);
    run_rx(ACK, ~ACK ^ 4'h4, empty_q);

    // Device with its pull-up on D-
    @(posedge clk_48MHz_i);
    pullupdp_d2p <= 1'b0;
    pullupdn_d2p <= 1'b1;
    flip_tb = 1'b1;
    repeat (2) @(negedge clk_48MHz_i);
    check_bit("connected", 32'(connected), 32'd1);
    repeat (4) run_tx(random_token());
    req = '{pid: ACK, has_token: 1'b0, addr: 7'h00, endp: 4'h0};
    run_tx(req);
    repeat (2) begin
      tok.pid = random_handshake();
      run_rx(tok.pid, ~tok.pid, empty_q);
    end
    repeat (2) begin
      tok = random_token();
      run_rx(tok.pid, ~tok.pid, ref_token_body(tok.addr, tok.endp));
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+test
hw/usb_host_pkg.sv
hw/usb_line_if.sv
hw/usb_packet_tx.sv
hw/usb_packet_rx.sv
hw/usb_host_link.sv
test/tb_usb_host_link.sv

//--- run_sim.sh
#!/bin/sh
# Builds the host link testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_usb_host_link \
  -f filelist.f -o tb_usb_host_link
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_usb_host_link 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
